/* tusca_fd.f */
tusca_pkg.sv
dht11_pkg.sv
contador_m.sv
medir_dht11.sv
avalia_clima.sv
controle_ventoinha.sv
transmissao_medida.sv
tusca_fd.sv
tb_dht11_sensor.sv
tb_tusca_fd.sv

/* Makefile */
TOP = tb_tusca_fd

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tusca_fd.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^PASS: all tests$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb_tusca_fd.sv */
module tb_tusca_fd;

  localparam logic [1:0] NORMAL          = 2'd0;
  localparam logic [1:0] CHECKSUM_ERRADO = 2'd1;
  localparam logic [1:0] MUDO            = 2'd2;
  localparam int ESPERA_LEITURA = 25_000;
  // Twice the delay, five reads, one transmission and two fan periods.
  localparam int LIMITE = 2 * (tusca_pkg::PERIODO_DELAY + 5 * ESPERA_LEITURA
                        + 40 * tusca_pkg::BAUD_DIV + 2 * tusca_pkg::PWM_PERIODO);

  logic        clock;
  logic        rst;
  logic        conta_delay;
  logic        zera_delay;
  logic        medir_dht11;
  logic        transmite_medida;
  wire         dht_bus;
  logic        fim_delay;
  logic        pronto_medida;
  logic        erro_medida;
  logic        rele;
  logic        pwm_ventoinha;
  logic        pronto_transmite_medida;
  logic        tx_serial;
  logic [2:0]  db_nivel_temperatura;
  logic [15:0] db_temperatura;
  logic [15:0] db_umidade;
  logic [1:0]  modo_sensor;
  logic [15:0] temp_ok;
  logic [15:0] umid_ok;
  int          erros;
  dht11_pkg::dht11_quadro_t quadro_sensor;

  pullup (dht_bus);

  tusca_fd DUT (.*);

  tb_dht11_sensor sensor (
    .clock   (clock),
    .modo    (modo_sensor),
    .quadro  (quadro_sensor),
    .dht_bus (dht_bus)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    repeat (LIMITE) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", LIMITE);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check(input string nome, input logic [31:0] obtido,
                       input logic [31:0] esperado);
    if (obtido !== esperado) begin
      erros++;
      $display("FAILED %s: got %h, expected %h", nome, obtido, esperado);
    end
  endtask

  // Level is one above the highest limit reached.
  function automatic int expected_level(input logic [15:0] t);
    for (int i = 6; i >= 0; i--) begin
      if (t >= tusca_pkg::LIM_TEMP[i]) begin
        return i + 1;
      end
    end
    return 0;
  endfunction

  function automatic dht11_pkg::dht11_quadro_t random_frame(input bit seco);
    dht11_pkg::dht11_quadro_t f;
    f.campos.umid_int = seco ? 8'(30 + $urandom % 30) : 8'(60 + $urandom % 40);
    f.campos.umid_dec = 8'($urandom % 10);
    f.campos.temp_int = 8'(15 + $urandom % 23);
    f.campos.temp_dec = 8'($urandom % 10);
    f.campos.checksum = f.octetos[4] + f.octetos[3] + f.octetos[2] + f.octetos[1];
    return f;
  endfunction

  // Strobe medir and wait for the end-of-read pulse.
  task automatic run_read(input logic [1:0] modo, input dht11_pkg::dht11_quadro_t f,
                          output logic visto);
    int n;
    n = 0;
    visto = 1'b0;
    @(posedge clock);
    modo_sensor   <= modo;
    quadro_sensor <= f;
    medir_dht11   <= 1'b1;
    @(posedge clock);
    medir_dht11 <= 1'b0;
    while (!visto && n < ESPERA_LEITURA) begin
      @(negedge clock);
      n++;
      visto = pronto_medida;
    end
    if (!visto) begin
      erros++;
      $display("No end-of-read pulse within %0d cycles", ESPERA_LEITURA);
    end
  endtask

  task automatic reset_state();
    @(negedge clock);
    check("fim_delay", 32'(fim_delay), 32'd0);
    check("pronto_medida", 32'(pronto_medida), 32'd0);
    check("erro_medida", 32'(erro_medida), 32'd0);
    check("rele", 32'(rele), 32'd0);
    check("pwm_ventoinha", 32'(pwm_ventoinha), 32'd0);
    check("pronto_transmite_medida", 32'(pronto_transmite_medida), 32'd0);
    check("db_nivel_temperatura", 32'(db_nivel_temperatura), 32'd0);
    check("tx_serial", 32'(tx_serial), 32'd1);
    check("db_temperatura", 32'(db_temperatura), 32'd0);
    check("db_umidade", 32'(db_umidade), 32'd0);
  endtask

  task automatic good_read(input int run);
    dht11_pkg::dht11_quadro_t f;
    logic                     visto;
    f = random_frame(run % 2 == 0);
    run_read(NORMAL, f, visto);
    if (visto) begin
      temp_ok = {f.campos.temp_int, f.campos.temp_dec};
      umid_ok = {f.campos.umid_int, f.campos.umid_dec};
      check("db_temperatura", 32'(db_temperatura), 32'(temp_ok));
      check("db_umidade", 32'(db_umidade), 32'(umid_ok));
      check("erro_medida", 32'(erro_medida), 32'd0);
      @(negedge clock);
      check("db_nivel_temperatura", 32'(db_nivel_temperatura), expected_level(temp_ok));
      check("rele", 32'(rele), 32'(umid_ok < tusca_pkg::LIM_UMIDADE));
    end
  endtask

  task automatic fan_duty();
    int altos;
    altos = 0;
    // One period to load the new duty, then one period measured.
    repeat (tusca_pkg::PWM_PERIODO + 2) @(negedge clock);
    repeat (tusca_pkg::PWM_PERIODO) begin
      @(negedge clock);
      if (pwm_ventoinha) begin
        altos++;
      end
    end
    check("pwm_ventoinha high cycles", altos, expected_level(temp_ok) * tusca_pkg::PWM_PASSO);
  endtask

  task automatic bad_read(input logic [1:0] modo);
    logic visto;
    run_read(modo, random_frame(1'b1), visto);
    if (visto) begin
      check("erro_medida", 32'(erro_medida), 32'd1);
      check("db_temperatura", 32'(db_temperatura), 32'(temp_ok));
      check("db_umidade", 32'(db_umidade), 32'(umid_ok));
    end
  endtask

  task automatic serial_frame();
    logic [39:0] linha;
    logic [7:0]  esperado [4];
    int          ciclos;
    // Expected bytes in the order they go out.
    esperado = '{umid_ok[15:8], umid_ok[7:0], temp_ok[15:8], temp_ok[7:0]};
    ciclos = 0;
    @(posedge clock);
    transmite_medida <= 1'b1;
    @(posedge clock);
    transmite_medida <= 1'b0;
    @(negedge clock);
    // Sample every bit in its middle.
    for (int k = 0; k < 40; k++) begin
      while (ciclos < k * tusca_pkg::BAUD_DIV + tusca_pkg::BAUD_DIV / 2) begin
        @(negedge clock);
        ciclos++;
      end
      linha[k] = tx_serial;
    end
    for (int b = 0; b < 4; b++) begin
      check("tx_serial start bit", 32'(linha[b * 10]), 32'd0);
      check("tx_serial data byte", 32'(linha[b * 10 + 1 +: 8]), 32'(esperado[b]));
      check("tx_serial stop bit", 32'(linha[b * 10 + 9]), 32'd1);
    end
    while (!pronto_transmite_medida && ciclos < 41 * tusca_pkg::BAUD_DIV) begin
      @(negedge clock);
      ciclos++;
    end
    check("pronto_transmite_medida cycle", ciclos, 40 * tusca_pkg::BAUD_DIV);
  endtask

  task automatic delay_count();
    int primeiro;
    primeiro = 0;
    @(posedge clock);
    zera_delay <= 1'b1;
    @(posedge clock);
    zera_delay  <= 1'b0;
    conta_delay <= 1'b1;
    for (int k = 1; k < tusca_pkg::PERIODO_DELAY; k++) begin
      @(posedge clock);
      if (k == tusca_pkg::PERIODO_DELAY - 1) begin
        conta_delay <= 1'b0;
      end
      @(negedge clock);
      if (fim_delay && primeiro == 0) begin
        primeiro = k;
      end
    end
    check("fim_delay rise cycle", primeiro, tusca_pkg::PERIODO_DELAY - 1);
    repeat (3) @(negedge clock);
    check("fim_delay", 32'(fim_delay), 32'd1);
    @(posedge clock);
    zera_delay <= 1'b1;
    @(posedge clock);
    zera_delay <= 1'b0;
    @(negedge clock);
    check("fim_delay after zera_delay", 32'(fim_delay), 32'd0);
  endtask

  initial begin
    erros = 0;
    void'($urandom(32'h7aea9909));
    rst              <= 1'b1;
    conta_delay      <= 1'b0;
    zera_delay       <= 1'b0;
    medir_dht11      <= 1'b0;
    transmite_medida <= 1'b0;
    modo_sensor      <= NORMAL;
    quadro_sensor    <= '0;
    repeat (8) @(posedge clock);
    rst <= 1'b0;
    reset_state();
    for (int r = 0; r < 3; r++) begin
      good_read(r);
    end
    fan_duty();
    bad_read(CHECKSUM_ERRADO);
    bad_read(MUDO);
    serial_frame();
    delay_count();
    $display("Errors: %0d", erros);
    if (erros == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb_dht11_sensor.sv */
module tb_dht11_sensor (
  input  logic                     clock,
  input  logic [1:0]               modo,
  input  dht11_pkg::dht11_quadro_t quadro,
  inout  wire                      dht_bus
);

  localparam logic [1:0] CHECKSUM_ERRADO = 2'd1;
  localparam logic [1:0] MUDO            = 2'd2;

  logic puxa;
  int   baixo;

  // Pulls the line low like the real open-drain sensor.
  assign dht_bus = puxa ? 1'b0 : 1'bz;

  task automatic hold_level(input logic nivel, input int ciclos);
    puxa <= ~nivel;
    repeat (ciclos) @(posedge clock);
  endtask

  task automatic send_frame();
    dht11_pkg::dht11_quadro_t enviado;
    logic [39:0]              bits;
    enviado = quadro;
    if (modo == CHECKSUM_ERRADO) begin
      enviado.campos.checksum = ~enviado.campos.checksum;
    end
    bits = enviado;
    // Sensor waits a little after the host lets go.
    hold_level(1'b1, 30);
    hold_level(1'b0, dht11_pkg::T_RESP);
    hold_level(1'b1, dht11_pkg::T_RESP);
    for (int i = 39; i >= 0; i--) begin
      hold_level(1'b0, dht11_pkg::T_BIT_BAIXO);
      hold_level(1'b1, bits[i] ? dht11_pkg::T_UM : dht11_pkg::T_ZERO);
    end
    hold_level(1'b0, dht11_pkg::T_BIT_BAIXO);
    puxa <= 1'b0;
  endtask

  // Answer any host low pulse longer than half the start time.
  initial begin
    puxa <= 1'b0;
    baixo = 0;
    forever begin
      @(posedge clock);
      if (dht_bus === 1'b0) begin
        baixo++;
      end else begin
        if (baixo > dht11_pkg::T_START / 2 && modo != MUDO) begin
          send_frame();
        end
        baixo = 0;
      end
    end
  end

endmodule

/* tusca_fd.sv */
module tusca_fd (
  input  logic        clock,
  input  logic        rst,
  input  logic        conta_delay,
  input  logic        zera_delay,
  input  logic        medir_dht11,
  input  logic        transmite_medida,
  inout  wire         dht_bus,
  output logic        fim_delay,
  output logic        pronto_medida,
  output logic        erro_medida,
  output logic        rele,
  output logic        pwm_ventoinha,
  output logic        pronto_transmite_medida,
  output logic        tx_serial,
  output logic [2:0]  db_nivel_temperatura,
  output logic [15:0] db_temperatura,
  output logic [15:0] db_umidade
);

  // Last good measurement feeds every consumer.
  medir_dht11 interface_dht11 (
    .clock       (clock),
    .rst         (rst),
    .medir       (medir_dht11),
    .dht_bus     (dht_bus),
    .pronto      (pronto_medida),
    .erro        (erro_medida),
    .temperatura (db_temperatura),
    .umidade     (db_umidade)
  );

  avalia_clima avaliacao (
    .clock       (clock),
    .rst         (rst),
    .temperatura (db_temperatura),
    .umidade     (db_umidade),
    .nivel       (db_nivel_temperatura),
    .rele        (rele)
  );

  controle_ventoinha cont_ventoinha (
    .clock         (clock),
    .rst           (rst),
    .nivel         (db_nivel_temperatura),
    .pwm_ventoinha (pwm_ventoinha)
  );

  transmissao_medida transmissao (
    .clock       (clock),
    .rst         (rst),
    .transmite   (transmite_medida),
    .temperatura (db_temperatura),
    .umidade     (db_umidade),
    .tx_serial   (tx_serial),
    .pronto      (pronto_transmite_medida)
  );

  contador_m #(
    .M (tusca_pkg::PERIODO_DELAY)
  ) contador_delay (
    .clock (clock),
    .rst   (rst),
    .zera  (zera_delay),
    .conta (conta_delay),
    .fim   (fim_delay)
  );

endmodule

/* transmissao_medida.sv */
module transmissao_medida (
  input  logic        clock,
  input  logic        rst,
  input  logic        transmite,
  input  logic [15:0] temperatura,
  input  logic [15:0] umidade,
  output logic        tx_serial,
  output logic        pronto
);

  localparam int BW = $clog2(tusca_pkg::BAUD_DIV);

  logic          ocupado;
  logic [31:0]   dados;
  logic [1:0]    byte_idx;
  logic [3:0]    bit_idx;
  logic [BW-1:0] baud_cnt;
  logic [7:0]    byte_atual;

  // Humidity high byte goes out first.
  assign byte_atual = dados[8 * (3 - byte_idx) +: 8];

  always_ff @(posedge clock) begin
    if (transmite && !ocupado) begin
      dados <= {umidade, temperatura};
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      ocupado   <= 1'b0;
      byte_idx  <= '0;
      bit_idx   <= '0;
      baud_cnt  <= '0;
      tx_serial <= 1'b1;
      pronto    <= 1'b0;
    end else begin
      pronto <= 1'b0;
      if (!ocupado) begin
        if (transmite) begin
          ocupado   <= 1'b1;
          byte_idx  <= '0;
          bit_idx   <= '0;
          baud_cnt  <= '0;
          tx_serial <= 1'b0;
        end
      end else if (baud_cnt != BW'(tusca_pkg::BAUD_DIV - 1)) begin
        baud_cnt <= baud_cnt + 1'b1;
      end else begin
        baud_cnt <= '0;
        if (bit_idx == 4'd9) begin
          bit_idx <= '0;
          if (byte_idx == 2'd3) begin
            ocupado   <= 1'b0;
            pronto    <= 1'b1;
            tx_serial <= 1'b1;
          end else begin
            byte_idx  <= byte_idx + 2'd1;
            tx_serial <= 1'b0;
          end
        end else begin
          bit_idx <= bit_idx + 4'd1;
          // Data LSB first, then the stop bit.
          tx_serial <= (bit_idx == 4'd8) ? 1'b1 : byte_atual[bit_idx[2:0]];
        end
      end
    end
  end

  // Line idles at mark.
  assert property (@(posedge clock) disable iff (rst) !ocupado |-> tx_serial);

endmodule

/* controle_ventoinha.sv */
module controle_ventoinha (
  input  logic       clock,
  input  logic       rst,
  input  logic [2:0] nivel,
  output logic       pwm_ventoinha
);

  localparam int CW = $clog2(tusca_pkg::PWM_PERIODO);

  logic [CW-1:0] cnt;
  logic [CW-1:0] duty;

  always_ff @(posedge clock) begin
    if (rst) begin
      cnt  <= '0;
      duty <= '0;
    end else if (cnt == CW'(tusca_pkg::PWM_PERIODO - 1)) begin
      cnt  <= '0;
      // Duty for the period that starts now.
      duty <= CW'(int'(nivel) * tusca_pkg::PWM_PASSO);
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign pwm_ventoinha = (cnt < duty);

endmodule

/* avalia_clima.sv */
module avalia_clima (
  input  logic        clock,
  input  logic        rst,
  input  logic [15:0] temperatura,
  input  logic [15:0] umidade,
  output logic [2:0]  nivel,
  output logic        rele
);

  logic [2:0] nivel_prox;

  // Number of limits reached.
  always_comb begin
    nivel_prox = '0;
    for (int i = 0; i < 7; i++) begin
      if (temperatura >= tusca_pkg::LIM_TEMP[i]) begin
        nivel_prox = nivel_prox + 3'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      nivel <= '0;
      rele  <= 1'b0;
    end else begin
      nivel <= nivel_prox;
      rele  <= (umidade < tusca_pkg::LIM_UMIDADE);
    end
  end

  // Previous temperature lies between the limit reached and the next one.
  assert property (@(posedge clock) disable iff (rst)
    (nivel == 3'd0 || $past(temperatura) >= tusca_pkg::LIM_TEMP[nivel - 3'd1]) &&
    (nivel == 3'd7 || $past(temperatura) < tusca_pkg::LIM_TEMP[nivel]));

endmodule

/* medir_dht11.sv */
module medir_dht11 (
  input  logic        clock,
  input  logic        rst,
  input  logic        medir,
  inout  wire         dht_bus,
  output logic        pronto,
  output logic        erro,
  output logic [15:0] temperatura,
  output logic [15:0] umidade
);

  localparam int CW = $clog2(dht11_pkg::T_START + 1);

  // Wait states alternate their awaited level, high on even codes.
  localparam logic [3:0] OCIOSO      = 4'd0;
  localparam logic [3:0] START       = 4'd1;
  localparam logic [3:0] LIBERA      = 4'd2;
  localparam logic [3:0] ESPERA_RESP = 4'd3;
  localparam logic [3:0] RESP_BAIXO  = 4'd4;
  localparam logic [3:0] RESP_ALTO   = 4'd5;
  localparam logic [3:0] BIT_BAIXO   = 4'd6;
  localparam logic [3:0] BIT_ALTO    = 4'd7;
  localparam logic [3:0] CONFERE     = 4'd8;

  logic [3:0]               estado;
  logic [3:0]               proximo;
  logic [CW-1:0]            cnt;
  logic [5:0]               n_bits;
  logic                     bus_s1;
  logic                     bus_s2;
  logic                     aguarda;
  logic                     expirou;
  logic [7:0]               soma;
  dht11_pkg::dht11_quadro_t quadro;

  // Open drain, low only during the start pulse.
  assign dht_bus = (estado == START) ? 1'b0 : 1'bz;

  always_ff @(posedge clock) begin
    if (rst) begin
      bus_s1 <= 1'b1;
      bus_s2 <= 1'b1;
    end else begin
      bus_s1 <= dht_bus;
      bus_s2 <= bus_s1;
    end
  end

  assign aguarda = ~estado[0];
  assign expirou = (cnt >= CW'(dht11_pkg::T_TIMEOUT));
  assign proximo = (estado == BIT_ALTO && n_bits != 6'd39) ? BIT_BAIXO : estado + 4'd1;

  assign soma = quadro.octetos[4] + quadro.octetos[3] + quadro.octetos[2]
              + quadro.octetos[1];

  always_ff @(posedge clock) begin
    if (rst) begin
      estado      <= OCIOSO;
      cnt         <= '0;
      n_bits      <= '0;
      pronto      <= 1'b0;
      erro        <= 1'b0;
      temperatura <= '0;
      umidade     <= '0;
    end else begin
      pronto <= 1'b0;
      cnt    <= cnt + 1'b1;
      case (estado)
        OCIOSO: begin
          cnt <= '0;
          if (medir) begin
            erro   <= 1'b0;
            n_bits <= '0;
            estado <= START;
          end
        end
        START: begin
          if (cnt == CW'(dht11_pkg::T_START - 1)) begin
            cnt    <= '0;
            estado <= LIBERA;
          end
        end
        LIBERA, ESPERA_RESP, RESP_BAIXO, RESP_ALTO, BIT_BAIXO, BIT_ALTO: begin
          if (expirou) begin
            erro   <= 1'b1;
            pronto <= 1'b1;
            estado <= OCIOSO;
          end else if (bus_s2 == aguarda) begin
            cnt    <= '0;
            estado <= proximo;
            if (estado == BIT_ALTO) begin
              // High time decides the bit value.
              quadro <= {quadro[38:0], cnt > CW'(dht11_pkg::LIMIAR_BIT)};
              n_bits <= n_bits + 6'd1;
            end
          end
        end
        CONFERE: begin
          pronto <= 1'b1;
          estado <= OCIOSO;
          if (soma == quadro.campos.checksum) begin
            umidade     <= {quadro.campos.umid_int, quadro.campos.umid_dec};
            temperatura <= {quadro.campos.temp_int, quadro.campos.temp_dec};
          end else begin
            erro <= 1'b1;
          end
        end
        default: begin
          estado <= OCIOSO;
        end
      endcase
    end
  end

  // End of a read is a single-cycle pulse.
  assert property (@(posedge clock) disable iff (rst) pronto |=> !pronto);

endmodule

/* contador_m.sv */
module contador_m #(
  parameter int M = 100
) (
  input  logic clock,
  input  logic rst,
  input  logic zera,
  input  logic conta,
  output logic fim
);

  localparam int N = (M > 1) ? $clog2(M) : 1;
  localparam logic [N-1:0] ULTIMO = N'(M - 1);

  logic [N-1:0] q;

  always_ff @(posedge clock) begin
    if (rst || zera) begin
      q <= '0;
    end else if (conta) begin
      q <= (q == ULTIMO) ? '0 : q + 1'b1;
    end
  end

  assign fim = (q == ULTIMO);

endmodule

/* dht11_pkg.sv */
package dht11_pkg;

  // Protocol timing in 1 us cycles.
  localparam int T_START     = 18000;
  localparam int T_RESP      = 80;
  localparam int T_BIT_BAIXO = 50;
  localparam int T_ZERO      = 26;
  localparam int T_UM        = 70;
  localparam int LIMIAR_BIT  = 45;
  localparam int T_TIMEOUT   = 1000;

  // Frame as sent on the wire, MSB first.
  typedef union packed {
    logic [4:0][7:0] octetos;
    struct packed {
      logic [7:0] umid_int;
      logic [7:0] umid_dec;
      logic [7:0] temp_int;
      logic [7:0] temp_dec;
      logic [7:0] checksum;
    } campos;
  } dht11_quadro_t;

endpackage

/* tusca_pkg.sv */
package tusca_pkg;

  // Wait between two readings, 2 s at 1 MHz.
  localparam int PERIODO_DELAY = 2_000_000;

  // Ascending limits in sensor format {integer, decimal}, 20.0 to 32.0 C.
  localparam logic [15:0] LIM_TEMP [7] = '{
    16'h1400,
    16'h1600,
    16'h1800,
    16'h1A00,
    16'h1C00,
    16'h1E00,
    16'h2000
  };

  // Relay turns on below 60.0 %.
  localparam logic [15:0] LIM_UMIDADE = 16'h3C00;

  localparam int PWM_PERIODO = 1000;
  localparam int PWM_PASSO   = 125;
  localparam int BAUD_DIV    = 104;

endpackage
